// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = uartTb
FILELIST  = uartSub.f
OBJDIR    = obj_dir
PASSMSG   = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/uartBrg.sv ====
// Fractional-N baud rate generator giving a 16x enable for the transmitter and receiver
`timescale 1ns/10ps

module uartBrg #(
   parameter int unsigned clkFrq = 50000000
) (
   input  logic   clk,
   input  logic   rst,
   uartLinkIf.brg link
);
   import uartPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Increment table
   //////////////////////////////////////////////////////////////////////

   logic [31:0] incrRom [16];
   logic [31:0] incr;

   // One constant per speed code from elaboration
   for (genvar i = 0; i < 16; i++)
   begin : genRom
      assign incrRom[i] = brgIncr(clkFrq, speedT'(i));
   end

   assign incr = incrRom[link.speed];

   //////////////////////////////////////////////////////////////////////
   // Phase accumulator
   //////////////////////////////////////////////////////////////////////

   logic [31:0] accum;
   logic        carry;

   // Carry out of the add is the tick one clock after the wrap
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         accum <= '0;
         carry <= 1'b0;
      end
      else if (!link.brgOn)
      begin
         // Park at zero while disabled so the restart phase is known
         accum <= '0;
         carry <= 1'b0;
      end
      else
      begin
         {carry, accum} <= {1'b0, accum} + {1'b0, incr};
      end
   end

   assign link.brgEn = carry;

endmodule

// ==== hdl/uartLinkIf.sv ====
// Internal link between register block, baud generator, transmitter and receiver
`timescale 1ns/10ps

interface uartLinkIf;
   import uartPkg::*;

   // Control from the register block
   speedT      speed;
   logic       brgOn;
   logic       loop;
   logic [7:0] txData;
   logic       txStart;

   // 16x baud tick
   logic       brgEn;

   // Transmitter state and serial line
   logic       txBusy;
   logic       txLine;

   // Receiver results, valid with the rxDone pulse
   logic [7:0] rxData;
   logic       rxDone;
   logic       rxFrameErr;

   modport regs (output speed, brgOn, loop, txData, txStart,
                 input  txBusy, rxData, rxDone, rxFrameErr);
   modport brg  (input  speed, brgOn, output brgEn);
   modport tx   (input  brgEn, txData, txStart, output txBusy, txLine);
   modport rx   (input  brgEn, loop, txLine, output rxData, rxDone, rxFrameErr);

endinterface

// ==== hdl/uartPkg.sv ====
// Shared constants and helpers for the UART subsystem, imported by the RTL and the testbench
package uartPkg;

   //////////////////////////////////////////////////////////////////////
   // Line speed
   //////////////////////////////////////////////////////////////////////

   // Speed code, index into rateTable
   typedef logic [3:0] speedT;

   // Standard DZ11 rates in baud
   // Entry 3 is really 134.5 baud, kept here as 134
   localparam int unsigned rateTable [16] = '{
      50, 75, 110, 134, 150, 300, 600, 1200,
      1800, 2000, 2400, 3600, 4800, 7200, 9600, 115200
   };

   // Phase increment for a 16x enable from a 32-bit accumulator
   // 2^32 * 16 * rate / clkHz, rounded to nearest
   function automatic logic [31:0] brgIncr(input longint unsigned clkHz, input speedT code);
      longint unsigned scaled;
      scaled = (64'(rateTable[code]) << 36) + clkHz / 2;
      return 32'(scaled / clkHz);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////////////////////////

   // Byte addresses, low nibble of the AXI address
   typedef enum logic [3:0] {
      ctrlAddr = 4'h0,
      statAddr = 4'h4,
      txAddr   = 4'h8,
      rxAddr   = 4'hC
   } regAddrT;

   // AXI response codes
   localparam logic [1:0] respOkay   = 2'b00;
   localparam logic [1:0] respSlvErr = 2'b10;

endpackage

// ==== hdl/uartRegs.sv ====
// AXI4-Lite register block for control, status and byte transfer of the UART
`timescale 1ns/10ps

module uartRegs (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   uartLinkIf.regs     link
);
   import uartPkg::*;

   logic        wrAccept;
   logic        wrOk;
   logic        wrByte;
   logic        rdAccept;
   logic        rdOk;
   regAddrT     wrAddr;
   regAddrT     rdAddr;
   logic [31:0] rdMux;
   logic [5:0]  ctrlQ;
   logic        txStartQ;
   logic [7:0]  txDataQ;
   logic [7:0]  rxDataQ;
   logic        rxValid;
   logic        overrun;
   logic        frameErr;
   logic        txDrop;
   logic        txBusyAny;

   // Four word-aligned registers, everything else is an error
   function automatic logic addrOk(input logic [31:0] addr);
      return (addr[31:4] == '0) && (addr[1:0] == 2'b00);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // AXI handshakes
   //////////////////////////////////////////////////////////////////////

   // No new request while a response is still held
   assign wrAccept  = awvalid && wvalid && !bvalid;
   assign awready   = wrAccept;
   assign wready    = wrAccept;
   assign rdAccept  = arvalid && !rvalid;
   assign arready   = rdAccept;
   assign wrAddr    = regAddrT'(awaddr[3:0]);
   assign rdAddr    = regAddrT'(araddr[3:0]);
   assign wrOk      = addrOk(awaddr);
   assign rdOk      = addrOk(araddr);
   assign wrByte    = wrAccept && wrOk && wstrb[0];
   assign txBusyAny = link.txBusy || txStartQ;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         if (wrAccept)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rdAccept)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // Response payload
   always_ff @(posedge clk)
   begin
      if (wrAccept)
         bresp <= wrOk ? respOkay : respSlvErr;
      if (rdAccept)
      begin
         rdata <= rdOk ? rdMux : '0;
         rresp <= rdOk ? respOkay : respSlvErr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Control and status
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ctrlQ    <= '0;
         txStartQ <= 1'b0;
         rxValid  <= 1'b0;
         overrun  <= 1'b0;
         frameErr <= 1'b0;
         txDrop   <= 1'b0;
      end
      else
      begin
         txStartQ <= 1'b0;
         if (wrByte)
         begin
            case (wrAddr)
               ctrlAddr: ctrlQ <= wdata[5:0];
               statAddr:
               begin
                  // Write one to clear the sticky flags
                  if (wdata[2])
                     overrun <= 1'b0;
                  if (wdata[3])
                     frameErr <= 1'b0;
                  if (wdata[4])
                     txDrop <= 1'b0;
               end
               txAddr:
                  if (txBusyAny)
                     txDrop <= 1'b1;
                  else
                     txStartQ <= 1'b1;
               default: ;
            endcase
         end
         if (rdAccept && rdOk && rdAddr == rxAddr)
            rxValid <= 1'b0;
         // New byte wins over a same-cycle read or clear
         if (link.rxDone)
         begin
            rxValid <= 1'b1;
            if (rxValid)
               overrun <= 1'b1;
            if (link.rxFrameErr)
               frameErr <= 1'b1;
         end
      end
   end

   // Byte holding registers
   always_ff @(posedge clk)
   begin
      if (wrByte && wrAddr == txAddr && !txBusyAny)
         txDataQ <= wdata[7:0];
      if (link.rxDone)
         rxDataQ <= link.rxData;
   end

   always_comb
   begin
      rdMux = '0;
      case (rdAddr)
         ctrlAddr: rdMux[5:0] = ctrlQ;
         statAddr: rdMux[4:0] = {txDrop, frameErr, overrun, rxValid, txBusyAny};
         txAddr:   rdMux[7:0] = txDataQ;
         rxAddr:   rdMux[7:0] = rxDataQ;
         default:  rdMux = '0;
      endcase
   end

   assign link.speed   = ctrlQ[3:0];
   assign link.brgOn   = ctrlQ[4];
   assign link.loop    = ctrlQ[5];
   assign link.txData  = txDataQ;
   assign link.txStart = txStartQ;

   // Responses hold, unchanged, until taken
   bHold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp));
   rHold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== hdl/uartRx.sv ====
// 8N1 receiver with 16x oversampling, start-bit check and stop-bit framing check
`timescale 1ns/10ps

module uartRx (
   input  logic  clk,
   input  logic  rst,
   input  logic  rxd,
   uartLinkIf.rx link
);

   typedef enum logic [1:0] {
      idle,
      start,
      data,
      stop
   } rxStateT;

   rxStateT    state;
   logic [1:0] rxSync;
   logic       rxIn;
   logic       rxPrev;
   logic [3:0] tickCnt;
   logic [2:0] bitCnt;
   logic [7:0] shiftReg;
   logic       doneQ;
   logic       errQ;
   logic       midBit;
   logic       halfBit;

   //////////////////////////////////////////////////////////////////////
   // Input conditioning
   //////////////////////////////////////////////////////////////////////

   // Two-stage synchronizer for the pin
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxSync <= 2'b11;
         rxPrev <= 1'b1;
      end
      else
      begin
         rxSync <= {rxSync[0], rxd};
         rxPrev <= rxIn;
      end
   end

   // Internal loopback takes the transmitter line directly
   assign rxIn = link.loop ? link.txLine : rxSync[1];

   // Middle of start bit, then middle of each later bit
   assign halfBit = link.brgEn && (tickCnt == 4'h7);
   assign midBit  = link.brgEn && (tickCnt == 4'hF);

   //////////////////////////////////////////////////////////////////////
   // Frame sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= idle;
         tickCnt <= '0;
         bitCnt  <= '0;
         doneQ   <= 1'b0;
         errQ    <= 1'b0;
      end
      else
      begin
         doneQ <= 1'b0;
         if (state != idle && link.brgEn)
            tickCnt <= tickCnt + 4'd1;
         case (state)
            idle:
               if (rxPrev && !rxIn)
               begin
                  state   <= start;
                  tickCnt <= '0;
               end
            start:
               if (halfBit)
               begin
                  // Still low half a bit later, else a glitch
                  state   <= rxIn ? idle : data;
                  tickCnt <= '0;
                  bitCnt  <= '0;
               end
            data:
               if (midBit)
               begin
                  bitCnt <= bitCnt + 3'd1;
                  if (bitCnt == 3'd7)
                     state <= stop;
               end
            stop:
               if (midBit)
               begin
                  state <= idle;
                  doneQ <= 1'b1;
                  errQ  <= !rxIn;
               end
         endcase
      end
   end

   // Shift in from the top so the first bit lands in bit 0
   always_ff @(posedge clk)
   begin
      if (state == data && midBit)
         shiftReg <= {rxIn, shiftReg[7:1]};
   end

   assign link.rxData     = shiftReg;
   assign link.rxDone     = doneQ;
   assign link.rxFrameErr = errQ;

endmodule

// ==== hdl/uartTop.sv ====
// UART subsystem top level, AXI4-Lite on plain ports and one 8N1 serial channel
`timescale 1ns/10ps

module uartTop #(
   parameter int unsigned clkFrq = 50000000
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   input  logic        rxd,
   output logic        txd
);

   // Shared link among the four blocks
   uartLinkIf link ();

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////

   uartRegs uartRegs_i (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .link    (link.regs)
   );

   // Only the baud generator depends on the clock rate
   uartBrg #(.clkFrq(clkFrq)) uartBrg_i (.clk(clk), .rst(rst), .link(link.brg));

   uartTx uartTx_i (.clk(clk), .rst(rst), .link(link.tx));

   uartRx uartRx_i (.clk(clk), .rst(rst), .rxd(rxd), .link(link.rx));

   assign txd = link.txLine;

endmodule

// ==== hdl/uartTx.sv ====
// 8N1 transmitter, serializes one byte per txStart on the 16x baud enable
`timescale 1ns/10ps

module uartTx (
   input  logic  clk,
   input  logic  rst,
   uartLinkIf.tx link
);

   typedef enum logic [1:0] {
      idle,
      start,
      data,
      stop
   } txStateT;

   txStateT    state;
   logic [3:0] tickCnt;
   logic [2:0] bitCnt;
   logic [7:0] shiftReg;
   logic       busy;
   logic       bitEnd;

   // Last of the sixteen ticks in a bit
   assign bitEnd = link.brgEn && (tickCnt == 4'hF);

   //////////////////////////////////////////////////////////////////////
   // Frame sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= idle;
         tickCnt <= '0;
         bitCnt  <= '0;
         busy    <= 1'b0;
      end
      else
      begin
         // Tick counter wraps by itself, held at zero in idle
         if (state != idle && link.brgEn)
            tickCnt <= tickCnt + 4'd1;
         case (state)
            idle:
               if (link.txStart)
                  busy <= 1'b1;
               else if (busy && link.brgEn)
                  // Byte pending, start bit lines up with a tick
                  state <= start;
            start:
               if (bitEnd)
               begin
                  state  <= data;
                  bitCnt <= '0;
               end
            data:
               if (bitEnd)
               begin
                  bitCnt <= bitCnt + 3'd1;
                  if (bitCnt == 3'd7)
                     state <= stop;
               end
            stop:
               if (bitEnd)
               begin
                  state <= idle;
                  busy  <= 1'b0;
               end
         endcase
      end
   end

   // Data shifter, LSB goes out first
   always_ff @(posedge clk)
   begin
      if (link.txStart)
         shiftReg <= link.txData;
      else if (state == data && bitEnd)
         shiftReg <= shiftReg >> 1;
   end

   // Line idles high, low for start
   assign link.txLine = (state == start) ? 1'b0 :
                        (state == data)  ? shiftReg[0] : 1'b1;
   assign link.txBusy = busy;

   // Register block must respect busy
   txNoOverlap: assert property (@(posedge clk) disable iff (rst)
      link.txStart |-> !link.txBusy);

endmodule

// ==== sim/uartTb.sv ====
// Self-checking testbench for uartTop that the file list runs as the simulation top
`timescale 1ns/10ps

module uartTb;
   import uartPkg::*;

   localparam int unsigned clkFrq    = 3686400;
   localparam int          serialBit = 32;
   localparam int          axiLimit  = 50;
   localparam logic [31:0] ctrlReg   = 32'(ctrlAddr);
   localparam logic [31:0] statReg   = 32'(statAddr);
   localparam logic [31:0] txReg     = 32'(txAddr);
   localparam logic [31:0] rxReg     = 32'(rxAddr);
   localparam logic [31:0] badReg    = 32'h10;

   logic        clk;
   logic        rst;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        rxd;
   logic        txd;

   // Scoreboard state shared by the sequence and the txd monitor
   int         mismatchCnt = 0;
   int         failCnt = 0;
   int         cycle = 0;
   int         bitClk = 32;
   int         stallMax = 3;
   int         frameCnt = 0;
   logic       txWasHigh = 1'b0;
   logic [7:0] expQ [$];

   uartTop #(.clkFrq(clkFrq)) uartTop_i (.*);

   always #5 clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   // Hard stop for a wedged run
   initial
   begin
      #2000000;
      $display("Simulation time limit reached before the test sequence ended");
      $display("CHECKS FAILED");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks and reference model
   //////////////////////////////////////////////////////////////////////

   task automatic reportFailure(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      failCnt++;
   endtask

   task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         mismatchCnt++;
      end
   endtask

   task automatic checkStat(input string name, input logic [4:0] got, input logic [4:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         mismatchCnt++;
      end
   endtask

   task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         mismatchCnt++;
      end
   endtask

   task automatic checkBitTime(input string name, input int got, input int exp);
      if (got != exp)
      begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         mismatchCnt++;
      end
   endtask

   // Accumulator step of 2^32 * 16 * rate / clock rounded to nearest
   function automatic logic [31:0] expectedIncr(input int code);
      longint unsigned num;
      num = 64'(rateTable[code]) * 64'd68719476736 + 64'(clkFrq) / 64'd2;
      return 32'(num / 64'(clkFrq));
   endfunction

   // Clocks per bit as sixteen ticks of 2^32 / incr clocks each
   function automatic int expectedBitTime(input int code);
      longint unsigned incr;
      incr = 64'(expectedIncr(code));
      return int'((64'd68719476736 + incr / 64'd2) / incr);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // AXI4-Lite master
   //////////////////////////////////////////////////////////////////////

   task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] expResp);
      int         waited;
      int         stall;
      logic       accepted;
      logic [1:0] resp;
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      waited  = 0;
      // Address and data are taken together on a clock edge
      @(posedge clk);
      while (!(awready === 1'b1 && wready === 1'b1) && waited < axiLimit)
      begin
         @(posedge clk);
         waited++;
      end
      accepted = (awready === 1'b1 && wready === 1'b1);
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (!accepted)
         reportFailure("timed out waiting for awready and wready");
      else if (bvalid !== 1'b1)
         reportFailure("bvalid did not rise in the cycle after the write was accepted");
      else
      begin
         resp  = bresp;
         stall = $urandom_range(stallMax);
         // Response must hold through the stall
         repeat (stall)
         begin
            @(negedge clk);
            if (bvalid !== 1'b1 || bresp !== resp)
               reportFailure("write response not held while bready was low");
         end
         bready = 1'b1;
         waited = 0;
         @(negedge clk);
         while (bvalid === 1'b1 && waited < axiLimit)
         begin
            @(negedge clk);
            waited++;
         end
         bready = 1'b0;
         if (bvalid === 1'b1)
            reportFailure("bvalid stayed high after bready");
         checkResp("bresp", resp, expResp);
      end
   endtask

   task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                          input logic [1:0] expResp);
      int         waited;
      int         stall;
      logic       accepted;
      logic [1:0] resp;
      data = '0;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      waited  = 0;
      @(posedge clk);
      while (arready !== 1'b1 && waited < axiLimit)
      begin
         @(posedge clk);
         waited++;
      end
      accepted = (arready === 1'b1);
      @(negedge clk);
      arvalid = 1'b0;
      if (!accepted)
         reportFailure("timed out waiting for arready");
      else if (rvalid !== 1'b1)
         reportFailure("rvalid did not rise in the cycle after the read was accepted");
      else
      begin
         resp  = rresp;
         data  = rdata;
         stall = $urandom_range(stallMax);
         repeat (stall)
         begin
            @(negedge clk);
            if (rvalid !== 1'b1 || rresp !== resp || rdata !== data)
               reportFailure("read response not held while rready was low");
         end
         rready = 1'b1;
         waited = 0;
         @(negedge clk);
         while (rvalid === 1'b1 && waited < axiLimit)
         begin
            @(negedge clk);
            waited++;
         end
         rready = 1'b0;
         if (rvalid === 1'b1)
            reportFailure("rvalid stayed high after rready");
         checkResp("rresp", resp, expResp);
      end
   endtask

   task automatic expectStatus(input logic [4:0] exp);
      logic [31:0] d;
      axiRead(statReg, d, respOkay);
      checkStat("status", d[4:0], exp);
   endtask

   // Poll until every flag in mask is set
   task automatic waitStatus(input logic [4:0] mask, input int limit);
      logic [31:0] d;
      int          start;
      start = cycle;
      d     = '0;
      while ((d[4:0] & mask) != mask && cycle - start < limit)
         axiRead(statReg, d, respOkay);
      if ((d[4:0] & mask) != mask)
         reportFailure("timed out waiting for status flags");
   endtask

   task automatic waitFrames(input int target, input int limit);
      int start;
      start = cycle;
      while (frameCnt < target && cycle - start < limit)
         @(negedge clk);
      if (frameCnt < target)
         reportFailure("timed out waiting for a frame on txd");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Serial driver and txd monitor
   //////////////////////////////////////////////////////////////////////

   // Start bit and eight data bits LSB first followed by the given stop level
   task automatic sendFrame(input logic [7:0] data, input logic stopVal);
      logic [9:0] frame;
      frame = {stopVal, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         rxd = frame[i];
         repeat (serialBit - 1) @(negedge clk);
      end
      @(negedge clk);
      rxd = 1'b1;
      repeat (2 * serialBit) @(negedge clk);
   endtask

   // Data from mid-bit samples and bit length from edge spacing
   task automatic captureFrame();
      int         lastEdge;
      int         runLen;
      int         nBits;
      logic       prevBit;
      logic       curBit;
      logic [9:0] bits;
      logic [7:0] expByte;
      lastEdge = 0;
      prevBit  = 1'b0;
      bits     = '0;
      for (int k = 1; k < 10 * bitClk; k++)
      begin
         @(negedge clk);
         curBit = txd;
         if (curBit !== prevBit)
         begin
            runLen = k - lastEdge;
            nBits  = (runLen + bitClk / 2) / bitClk;
            if (nBits == 0)
               nBits = 1;
            checkBitTime("txd bit run", runLen, nBits * bitClk);
            lastEdge = k;
            prevBit  = curBit;
         end
         if (k % bitClk == bitClk / 2)
            bits[k / bitClk] = curBit;
      end
      frameCnt++;
      if (bits[0] !== 1'b0)
         reportFailure("start bit on txd was not low at mid-bit");
      if (bits[9] !== 1'b1)
         reportFailure("stop bit on txd was low");
      if (expQ.size() == 0)
         reportFailure("unexpected frame on txd");
      else
      begin
         expByte = expQ.pop_front();
         checkByte("txd data", bits[8:1], expByte);
      end
   endtask

   always
   begin : txMonitor
      @(negedge clk);
      if (!rst && txWasHigh && txd === 1'b0)
         captureFrame();
      txWasHigh = (txd === 1'b1);
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin : mainSeq
      int          target;
      logic [31:0] d;
      logic [7:0]  b;
      logic [7:0]  b2;
      logic [3:0]  spd;
      logic        lowSeen;
      clk     = 1'b0;
      rst     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      rxd     = 1'b1;
      void'($urandom(32'h8080));
      target  = 0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      if (bvalid !== 1'b0 || rvalid !== 1'b0 || awready !== 1'b0 || wready !== 1'b0
          || arready !== 1'b0 || txd !== 1'b1)
         reportFailure("control outputs or txd not idle after reset");

      // Transmit at 115200 with 32 clocks per bit
      bitClk = expectedBitTime(15);
      axiWrite(ctrlReg, 32'h1F, respOkay);
      for (int i = 0; i < 6; i++)
      begin
         b = 8'($urandom);
         expQ.push_back(b);
         axiWrite(txReg, 32'(b), respOkay);
         target++;
         waitFrames(target, 12 * bitClk);
      end

      // Receive clean frames
      for (int i = 0; i < 4; i++)
      begin
         b = 8'($urandom);
         sendFrame(b, 1'b1);
         waitStatus(5'b00010, 20 * serialBit);
         expectStatus(5'b00010);
         axiRead(rxReg, d, respOkay);
         checkByte("rx data", d[7:0], b);
         expectStatus(5'b00000);
      end

      // Low stop bit gives a framing error
      b = 8'($urandom);
      sendFrame(b, 1'b0);
      waitStatus(5'b00010, 20 * serialBit);
      expectStatus(5'b01010);
      axiRead(rxReg, d, respOkay);
      checkByte("rx data with framing error", d[7:0], b);

      // Two frames without a read keep the second byte
      b  = 8'($urandom);
      b2 = 8'($urandom);
      sendFrame(b, 1'b1);
      waitStatus(5'b00010, 20 * serialBit);
      sendFrame(b2, 1'b1);
      waitStatus(5'b00100, 20 * serialBit);
      expectStatus(5'b01110);
      axiRead(rxReg, d, respOkay);
      checkByte("rx data after overrun", d[7:0], b2);
      axiWrite(statReg, 32'h1C, respOkay);
      expectStatus(5'b00000);

      // Loopback at 9600 with a fractional increment
      axiWrite(ctrlReg, 32'h00, respOkay);
      bitClk = expectedBitTime(14);
      axiWrite(ctrlReg, 32'h3E, respOkay);
      for (int i = 0; i < 2; i++)
      begin
         b = 8'($urandom);
         expQ.push_back(b);
         axiWrite(txReg, 32'(b), respOkay);
         target++;
         waitFrames(target, 12 * bitClk);
         waitStatus(5'b00010, 4 * bitClk);
         axiRead(rxReg, d, respOkay);
         checkByte("loopback rx data", d[7:0], b);
      end
      axiWrite(ctrlReg, 32'h00, respOkay);
      bitClk = expectedBitTime(15);
      axiWrite(ctrlReg, 32'h1F, respOkay);

      // Second write while busy is dropped
      b  = 8'($urandom);
      b2 = 8'($urandom);
      expQ.push_back(b);
      axiWrite(txReg, 32'(b), respOkay);
      axiWrite(txReg, 32'(b2), respOkay);
      expectStatus(5'b10001);
      target++;
      waitFrames(target, 12 * bitClk);
      // Window for a stray second frame
      repeat (12 * bitClk) @(negedge clk);
      axiWrite(statReg, 32'h10, respOkay);
      expectStatus(5'b00000);

      // Control read-back and bad addresses under long stalls
      stallMax = 12;
      for (int i = 0; i < 6; i++)
      begin
         spd = 4'($urandom);
         axiWrite(ctrlReg, 32'({2'b01, spd}), respOkay);
         axiRead(ctrlReg, d, respOkay);
         checkByte("ctrl readback", d[7:0], 8'({2'b01, spd}));
      end
      axiWrite(ctrlReg, 32'h1F, respOkay);
      axiRead(badReg, d, respSlvErr);
      axiWrite(badReg, 32'hA5, respSlvErr);
      stallMax = 3;

      // Byte waits with the line idle while enable is low
      axiWrite(ctrlReg, 32'h0F, respOkay);
      b = 8'($urandom);
      axiWrite(txReg, 32'(b), respOkay);
      lowSeen = 1'b0;
      repeat (2000)
      begin
         @(negedge clk);
         if (txd !== 1'b1)
            lowSeen = 1'b1;
      end
      if (lowSeen)
         reportFailure("txd left idle while the baud generator was off");
      expQ.push_back(b);
      axiWrite(ctrlReg, 32'h1F, respOkay);
      target++;
      waitFrames(target, 12 * bitClk);
      expectStatus(5'b00000);

      if (expQ.size() != 0)
         reportFailure("frames expected on txd were never seen");
      $display("Error counts: %0d mismatches, %0d other failures", mismatchCnt, failCnt);
      if (mismatchCnt == 0 && failCnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== uartSub.f ====
hdl/uartPkg.sv
hdl/uartLinkIf.sv
hdl/uartBrg.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartRegs.sv
hdl/uartTop.sv
sim/uartTb.sv
